/* periph_cfg.svh */
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// ****************************************
// Bus and counter widths
// ****************************************

`define DATA_N		8
`define PERIPH_N	2
`define PR_N		8

// ****************************************
// SPI register map
// ****************************************

`define SPI_CTRL	2'd0
`define SPI_CTRL_PR_	0		// Prescale select field, lowest bit
`define SPI_CTRL_PR_N	3		// Prescale select field width
`define SPI_CTRL_CPHA	8'h08
`define SPI_CTRL_CPOL	8'h10
`define SPI_CTRL_IE	8'h20
`define SPI_CTRL_EN	8'h80
`define SPI_CTRL_MASK	8'hbf

`define SPI_STAT	2'd1
`define SPI_STAT_TXE_	0
`define SPI_STAT_RXNE_	1
`define SPI_STAT_BSY_	2
`define SPI_STAT_TXE	8'h01
`define SPI_STAT_RXNE	8'h02
`define SPI_STAT_BSY	8'h04
`define SPI_STAT_MASK	8'h07

`define SPI_DATA	2'd2

`endif

/* periph_pkg.sv */
`default_nettype none
`include "periph_cfg.svh"

package periph_pkg;

	typedef logic [`DATA_N - 1:0] data_t;
	typedef logic [`PERIPH_N - 1:0] addr_t;

	// Counts bit positions within one frame
	typedef logic [$clog2(`DATA_N + 1) - 1:0] bitcnt_t;

	typedef enum logic [1:0] {
		IDLE, LEAD, TRAIL, DONE
	} spi_state_t;

	typedef enum logic [1:0] {
		WAIT_REQ, STROBE, HOLD_ACK, WAIT_REL
	} bridge_state_t;

endpackage

`default_nettype wire

/* prescaler.sv */
`default_nettype none
`timescale 1ns/1ps

module prescaler #(
	parameter int n = 8
) (
	input wire logic clk,
	input wire logic n_reset,
	input wire logic clear,
	output logic [n:0] counter
);

	// ****************************************
	// Divided clock bits
	// ****************************************

	// Bit k of the counter toggles every 2^k cycles
	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			counter <= '0;
		end else if (clear) begin
			counter <= '0;			// Restart so the first half period is full length
		end else begin
			counter <= counter + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* spi_master.sv */
`default_nettype none
`timescale 1ns/1ps
`include "periph_cfg.svh"

module spi_master (
	input wire logic clk,
	input wire logic n_reset,
	input wire logic bus_we,
	input wire logic bus_oe,
	input wire logic periph_sel,
	input wire periph_pkg::addr_t periph_addr,
	inout wire periph_pkg::data_t bus_data,
	output logic interrupt,
	input wire logic miso,
	output logic cs,
	output logic mosi,
	output logic sck
);

	import periph_pkg::*;

	// ****************************************
	// Register access
	// ****************************************

	data_t reg_ctrl;
	data_t reg_tx;
	data_t reg_rx;
	data_t stat_word;
	data_t periph_data;
	logic txe;
	logic rxne;
	logic bsy;
	logic we;
	logic oe;
	logic wr_data;
	logic rd_data;

	assign we = periph_sel & bus_we;
	assign oe = periph_sel & bus_oe;
	assign wr_data = we && (periph_addr == `SPI_DATA);
	assign rd_data = oe && (periph_addr == `SPI_DATA);

	assign bus_data = oe ? periph_data : 'z;

	always_comb begin
		stat_word = '0;
		stat_word[`SPI_STAT_TXE_] = txe;
		stat_word[`SPI_STAT_RXNE_] = rxne;
		stat_word[`SPI_STAT_BSY_] = bsy;
	end

	always_comb begin
		case (periph_addr)
			`SPI_CTRL: periph_data = reg_ctrl & `SPI_CTRL_MASK;
			`SPI_STAT: periph_data = stat_word & `SPI_STAT_MASK;
			`SPI_DATA: periph_data = reg_rx;
			default: periph_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			reg_ctrl <= '0;
		end else if (we && (periph_addr == `SPI_CTRL)) begin
			reg_ctrl <= bus_data;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_data) begin
			reg_tx <= bus_data;		// Overwrites a word still waiting
		end
	end

	// ****************************************
	// Control decode
	// ****************************************

	logic enabled;
	logic cpha;
	logic cpol;
	logic ie;
	logic [`SPI_CTRL_PR_N - 1:0] pr_sel;

	assign enabled = (reg_ctrl & `SPI_CTRL_EN) != '0;
	assign cpha = (reg_ctrl & `SPI_CTRL_CPHA) != '0;
	assign cpol = (reg_ctrl & `SPI_CTRL_CPOL) != '0;
	assign ie = (reg_ctrl & `SPI_CTRL_IE) != '0;
	assign pr_sel = reg_ctrl[`SPI_CTRL_PR_ +: `SPI_CTRL_PR_N];

	// ****************************************
	// Half period ticks
	// ****************************************

	spi_state_t state;
	logic [`PR_N:0] pr_count;
	logic pr_clear;
	logic pr_bit;
	logic pr_bit_d;
	logic tick;

	assign pr_clear = (state == IDLE);

	prescaler #(
		.n(`PR_N)
	) u_prescaler (
		.clk(clk),
		.n_reset(n_reset),
		.clear(pr_clear),
		.counter(pr_count)
	);

	assign pr_bit = pr_count[pr_sel + 1];

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			pr_bit_d <= 1'b0;
		end else if (pr_clear) begin
			pr_bit_d <= 1'b0;
		end else begin
			pr_bit_d <= pr_bit;
		end
	end

	// Each change of the selected bit ends one half period
	assign tick = pr_bit ^ pr_bit_d;

	// ****************************************
	// Shift engine
	// ****************************************

	data_t sh_data;
	data_t rx_word;
	bitcnt_t bitcnt;
	logic phase;
	logic rx_bit;
	logic sample;
	logic load;
	logic last_bit;

	assign load = enabled && !txe && (state == IDLE || state == DONE);
	assign last_bit = (bitcnt == bitcnt_t'(`DATA_N - 1));
	assign sample = tick && (cpha ? (state == TRAIL) : (state == LEAD));

	// With CPHA set the final sample has not been shifted in yet
	assign rx_word = cpha ? {sh_data[`DATA_N - 2:0], rx_bit} : sh_data;

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			state <= IDLE;
			phase <= 1'b0;
			bitcnt <= '0;
			sh_data <= '0;
		end else if (!enabled) begin
			state <= IDLE;
			phase <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (load) begin
						sh_data <= reg_tx;
						bitcnt <= '0;
						state <= LEAD;
					end
				end
				LEAD: begin
					if (tick) begin
						phase <= 1'b1;
						state <= TRAIL;
						if (cpha && bitcnt != '0) begin
							sh_data <= {sh_data[`DATA_N - 2:0], rx_bit};
						end
					end
				end
				TRAIL: begin
					if (tick) begin
						phase <= 1'b0;
						if (!cpha) begin
							sh_data <= {sh_data[`DATA_N - 2:0], rx_bit};
						end
						if (last_bit) begin
							state <= DONE;
						end else begin
							bitcnt <= bitcnt + 1'b1;
							state <= LEAD;
						end
					end
				end
				DONE: begin
					if (load) begin
						sh_data <= reg_tx;	// Next word follows with no gap
						bitcnt <= '0;
						state <= LEAD;
					end else begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sample) begin
			rx_bit <= miso;
		end
	end

	always_ff @(posedge clk) begin
		if (state == DONE) begin
			reg_rx <= rx_word;		// A word not yet read is lost
		end
	end

	// ****************************************
	// Status flags
	// ****************************************

	assign bsy = (state != IDLE);

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			txe <= 1'b1;
			rxne <= 1'b0;
		end else if (!enabled) begin
			txe <= 1'b1;
			rxne <= 1'b0;
		end else begin
			if (state == DONE) begin
				rxne <= 1'b1;
			end else if (rd_data) begin
				rxne <= 1'b0;
			end
			if (wr_data) begin
				txe <= 1'b0;
			end else if (load) begin
				txe <= 1'b1;
			end
		end
	end

	// ****************************************
	// Pins
	// ****************************************

	assign cs = enabled;
	assign sck = enabled & (phase ^ cpol);
	assign mosi = sh_data[`DATA_N - 1];	// MSB first
	assign interrupt = rxne & ie;

endmodule

`default_nettype wire

/* bus_bridge.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_bridge (
	input wire logic clk,
	input wire logic n_reset,
	input wire logic req,
	input wire logic we,
	input wire periph_pkg::addr_t addr,
	input wire periph_pkg::data_t wdata,
	output logic ack,
	output periph_pkg::data_t rdata,
	output logic periph_sel,
	output logic bus_we,
	output logic bus_oe,
	output periph_pkg::addr_t periph_addr,
	inout wire periph_pkg::data_t bus_data
);

	import periph_pkg::*;

	bridge_state_t state;
	data_t wdata_r;
	logic we_r;

	assign bus_data = (periph_sel && bus_we) ? wdata_r : 'z;

	// ****************************************
	// Handshake and strobe
	// ****************************************

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			state <= WAIT_REQ;
			ack <= 1'b0;
			periph_sel <= 1'b0;
			bus_we <= 1'b0;
			bus_oe <= 1'b0;
		end else begin
			case (state)
				WAIT_REQ: begin
					if (req) begin
						state <= STROBE;
					end
				end
				STROBE: begin
					periph_sel <= 1'b1;	// Held for exactly one cycle
					bus_we <= we_r;
					bus_oe <= !we_r;
					state <= HOLD_ACK;
				end
				HOLD_ACK: begin
					if (!ack) begin
						periph_sel <= 1'b0;
						bus_we <= 1'b0;
						bus_oe <= 1'b0;
						ack <= 1'b1;
					end else if (!req) begin
						state <= WAIT_REL;
					end
				end
				WAIT_REL: begin
					ack <= 1'b0;
					state <= WAIT_REQ;
				end
				default: state <= WAIT_REQ;
			endcase
		end
	end

	// Request captured once, read data taken at the end of the strobe
	always_ff @(posedge clk) begin
		if (state == WAIT_REQ && req) begin
			we_r <= we;
			wdata_r <= wdata;
			periph_addr <= addr;
		end
		if (state == HOLD_ACK && !ack && !we_r) begin
			rdata <= bus_data;
		end
	end

endmodule

`default_nettype wire

/* periph_top.sv */
`default_nettype none
`timescale 1ns/1ps

module periph_top (
	input wire logic clk,
	input wire logic n_reset,
	input wire logic req,
	input wire logic we,
	input wire periph_pkg::addr_t addr,
	input wire periph_pkg::data_t wdata,
	input wire logic miso,
	output logic ack,
	output periph_pkg::data_t rdata,
	output logic cs,
	output logic sck,
	output logic mosi,
	output logic interrupt
);

	import periph_pkg::*;

	// ****************************************
	// Internal peripheral bus
	// ****************************************

	logic periph_sel;
	logic bus_we;
	logic bus_oe;
	addr_t periph_addr;
	wire data_t bus_data;			// Shared tri-state data line

	bus_bridge u_bridge (
		.clk(clk),
		.n_reset(n_reset),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.periph_sel(periph_sel),
		.bus_we(bus_we),
		.bus_oe(bus_oe),
		.periph_addr(periph_addr),
		.bus_data(bus_data)
	);

	spi_master u_spi (
		.clk(clk),
		.n_reset(n_reset),
		.bus_we(bus_we),
		.bus_oe(bus_oe),
		.periph_sel(periph_sel),
		.periph_addr(periph_addr),
		.bus_data(bus_data),
		.interrupt(interrupt),
		.miso(miso),
		.cs(cs),
		.mosi(mosi),
		.sck(sck)
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
	parameter real period = 40.0,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic n_reset
);

	initial begin
		clk = 1'b0;
		forever #(period / 2.0) clk = ~clk;
	end

	initial begin
		n_reset = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#5 n_reset = 1'b1;		// Released away from the clock edge
	end

endmodule

`default_nettype wire

/* tb_periph.sv */
`default_nettype none
`timescale 1ns/1ps
`include "periph_cfg.svh"

module tb_periph;

	import periph_pkg::*;

	localparam int drive_delay = 5;
	localparam int timeout_cycles = 330000;	// Twice 40 transfers of 16 half periods at 256 cycles

	logic clk;
	logic n_reset;
	logic req;
	logic we;
	addr_t addr;
	data_t wdata;
	logic miso;
	logic ack;
	data_t rdata;
	logic cs;
	logic sck;
	logic mosi;
	logic interrupt;

	logic [31:0] lfsr_state = 32'h3609;
	data_t ctrl_model = '0;
	data_t slave_rx_q[$];
	data_t slave_tx_q[$];
	int cycles = 0;
	logic mode_cpha;
	logic mode_cpol;
	logic mode_ie;

	assign mode_cpha = (ctrl_model & `SPI_CTRL_CPHA) != '0;
	assign mode_cpol = (ctrl_model & `SPI_CTRL_CPOL) != '0;
	assign mode_ie = (ctrl_model & `SPI_CTRL_IE) != '0;

	tb_clock #(.period(40.0), .reset_cycles(4)) u_clock (.clk(clk), .n_reset(n_reset));

	periph_top uut (
		.clk(clk),
		.n_reset(n_reset),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.miso(miso),
		.ack(ack),
		.rdata(rdata),
		.cs(cs),
		.sck(sck),
		.mosi(mosi),
		.interrupt(interrupt)
	);

	// Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once for every bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input data_t got, input data_t exp);
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_pins(input logic exp_cs, input logic exp_sck, input logic exp_irq);
		check_value("cs", data_t'(cs), data_t'(exp_cs));
		check_value("sck", data_t'(sck), data_t'(exp_sck));
		check_value("interrupt", data_t'(interrupt), data_t'(exp_irq));
	endtask

	// ****************************************
	// Host port
	// ****************************************

	task automatic bus_access(input logic write, input addr_t a, input data_t d, output data_t q);
		@(posedge clk);
		#(drive_delay);
		req = 1'b1;
		we = write;
		addr = a;
		wdata = d;
		do begin
			@(posedge clk);
			#(drive_delay);
		end while (!ack);
		q = rdata;			// Valid while ack is high
		req = 1'b0;
		do begin
			@(posedge clk);
			#(drive_delay);
		end while (ack);
	endtask

	task automatic reg_write(input addr_t a, input data_t d);
		data_t ignored;
		bus_access(1'b1, a, d, ignored);
		if (a == `SPI_CTRL) begin
			ctrl_model = d & `SPI_CTRL_MASK;
		end
	endtask

	task automatic expect_reg(input string name, input addr_t a, input data_t exp);
		data_t q;
		bus_access(1'b0, a, '0, q);
		check_value(name, q, exp);
	endtask

	task automatic poll_stat(input data_t mask, input data_t want, output data_t stat);
		do begin
			bus_access(1'b0, `SPI_STAT, '0, stat);
		end while ((stat & mask) != want);
	endtask

	// ****************************************
	// SPI slave model
	// ****************************************

	data_t slave_word;
	data_t slave_shift;
	int bit_idx;
	logic sck_d;
	logic cs_d;

	initial begin
		miso = 1'b0;
		sck_d = 1'b0;
		cs_d = 1'b0;
		bit_idx = 0;
		slave_word = data_t'(random_bits(8));
		forever begin
			@(posedge clk);
			#(drive_delay);
			if (!(cs && cs_d)) begin
				bit_idx = 0;
				miso = slave_word[`DATA_N - 1];	// First bit ready before the first edge
			end else if (sck != sck_d && sck != mode_cpol) begin
				if (mode_cpha) begin
					miso = slave_word[`DATA_N - 1 - bit_idx];
				end else begin
					slave_shift = {slave_shift[`DATA_N - 2:0], mosi};
				end
			end else if (sck != sck_d) begin
				if (mode_cpha) begin
					slave_shift = {slave_shift[`DATA_N - 2:0], mosi};
				end
				bit_idx++;
				if (bit_idx == `DATA_N) begin
					slave_rx_q.push_back(slave_shift);
					slave_tx_q.push_back(slave_word);
					slave_word = data_t'(random_bits(8));
					bit_idx = 0;
				end
				if (!mode_cpha) begin
					miso = slave_word[`DATA_N - 1 - bit_idx];
				end
			end
			cs_d = cs;
			sck_d = sck;
		end
	end

	// ****************************************
	// Transfers
	// ****************************************

	task automatic run_transfer();
		data_t tx;
		data_t q;
		tx = data_t'(random_bits(8));
		reg_write(`SPI_DATA, tx);
		poll_stat(`SPI_STAT_BSY, '0, q);
		check_value("stat", q, `SPI_STAT_TXE | `SPI_STAT_RXNE);
		check_pins(1'b1, mode_cpol, mode_ie);
		assert (slave_rx_q.size() == 1 && slave_tx_q.size() == 1) else
			report_failure("Slave model did not see exactly one word");
		check_value("slave_rx", slave_rx_q.pop_front(), tx);
		expect_reg("rx_data", `SPI_DATA, slave_tx_q.pop_front());
		expect_reg("stat", `SPI_STAT, `SPI_STAT_TXE);
		check_pins(1'b1, mode_cpol, 1'b0);
	endtask

	task automatic run_back_to_back();
		data_t w0;
		data_t w1;
		data_t q;
		w0 = data_t'(random_bits(8));
		w1 = data_t'(random_bits(8));
		reg_write(`SPI_DATA, w0);
		expect_reg("stat", `SPI_STAT, `SPI_STAT_TXE | `SPI_STAT_BSY);
		reg_write(`SPI_DATA, w1);
		expect_reg("stat", `SPI_STAT, `SPI_STAT_BSY);
		poll_stat(`SPI_STAT_RXNE, `SPI_STAT_RXNE, q);
		// Second word already loaded with no idle gap
		check_value("stat", q, `SPI_STAT_TXE | `SPI_STAT_RXNE | `SPI_STAT_BSY);
		check_value("interrupt", data_t'(interrupt), data_t'(mode_ie));
		poll_stat(`SPI_STAT_BSY, '0, q);
		check_value("stat", q, `SPI_STAT_TXE | `SPI_STAT_RXNE);
		check_pins(1'b1, mode_cpol, mode_ie);
		assert (slave_rx_q.size() == 2 && slave_tx_q.size() == 2) else
			report_failure("Slave model did not see exactly two words");
		check_value("slave_rx", slave_rx_q.pop_front(), w0);
		check_value("slave_rx", slave_rx_q.pop_front(), w1);
		void'(slave_tx_q.pop_front());
		expect_reg("rx_data", `SPI_DATA, slave_tx_q.pop_front());
		check_pins(1'b1, mode_cpol, 1'b0);
	endtask

	// ****************************************
	// Test sequence and timeout
	// ****************************************

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	initial begin
		wait (cycles >= timeout_cycles);
		$display("Timeout: the test did not finish within %0d cycles", timeout_cycles);
		$display("TEST FAIL");
		$fatal(1);
	end

	initial begin
		data_t r;
		data_t ctrl;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		@(posedge n_reset);
		check_value("ack", data_t'(ack), '0);
		check_pins(1'b0, 1'b0, 1'b0);
		expect_reg("ctrl", `SPI_CTRL, '0);
		expect_reg("stat", `SPI_STAT, `SPI_STAT_TXE);
		r = data_t'(random_bits(8));
		reg_write(`SPI_CTRL, r);
		expect_reg("ctrl", `SPI_CTRL, r & `SPI_CTRL_MASK);
		expect_reg("stat", `SPI_STAT, `SPI_STAT_TXE);
		expect_reg("unused", 2'd3, '0);
		reg_write(`SPI_CTRL, '0);
		for (int m = 0; m < 4; m++) begin
			ctrl = `SPI_CTRL_EN | data_t'(random_bits(2));
			ctrl = ctrl | (m[0] ? `SPI_CTRL_CPHA : 8'h00) | (m[1] ? `SPI_CTRL_CPOL : 8'h00);
			ctrl = ctrl | ((m[0] ^ m[1]) ? `SPI_CTRL_IE : 8'h00);
			reg_write(`SPI_CTRL, ctrl & ~`SPI_CTRL_EN);	// Mode changes only while disabled
			reg_write(`SPI_CTRL, ctrl);
			check_pins(1'b1, mode_cpol, 1'b0);
			run_transfer();
			ctrl = (ctrl & 8'hf8) | data_t'(random_bits(2) + 1);
			reg_write(`SPI_CTRL, ctrl);
			run_back_to_back();
		end
		reg_write(`SPI_DATA, data_t'(random_bits(8)));
		reg_write(`SPI_CTRL, ctrl & ~`SPI_CTRL_EN);	// Lands in the middle of the shift
		check_pins(1'b0, 1'b0, 1'b0);
		expect_reg("stat", `SPI_STAT, `SPI_STAT_TXE);
		reg_write(`SPI_CTRL, ctrl);
		run_transfer();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
periph_pkg.sv
prescaler.sv
spi_master.sv
bus_bridge.sv
periph_top.sv
tb_clock.sv
tb_periph.sv
